// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

   localparam int XLEN       = 32;   // Datapath width
   localparam int NUM_REGS   = 32;   // Architectural registers x0 to x31
   localparam int DMEM_WORDS = 64;   // Data memory depth in words

   typedef logic [XLEN-1:0]               word_t;     // Data, addresses, instructions
   typedef logic [$clog2(NUM_REGS)-1:0]   reg_id_t;   // Register index
   typedef logic [$clog2(DMEM_WORDS)-1:0] dmem_idx_t; // Data memory word index

   localparam word_t NOP_INSTR = 32'h0000_0013;   // ADDI x0,x0,0

   // Major opcodes of the supported subset
   localparam logic [6:0] OP_REG    = 7'b0110011;   // ADD SUB AND OR XOR SLT
   localparam logic [6:0] OP_IMM    = 7'b0010011;   // ADDI
   localparam logic [6:0] OP_LUI    = 7'b0110111;
   localparam logic [6:0] OP_LOAD   = 7'b0000011;   // LW
   localparam logic [6:0] OP_STORE  = 7'b0100011;   // SW
   localparam logic [6:0] OP_BRANCH = 7'b1100011;   // BEQ BNE
   localparam logic [6:0] OP_JAL    = 7'b1101111;

   typedef enum logic [2:0] {
      ALU_ADD,     // Zero value so a cleared control is an add
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,     // Signed less than
      ALU_PASSB    // LUI passes the immediate
   } alu_op_e;

   typedef enum logic [1:0] {
      FWD_NONE,    // Value from the register file
      FWD_EX_MEM,  // Result one stage ahead
      FWD_MEM_WB   // Write-back value
   } fwd_sel_e;

   typedef struct packed {
      alu_op_e alu_op;
      logic    alu_src_imm;   // Operand B from immediate
      logic    reg_write;
      logic    mem_read;
      logic    mem_write;
      logic    is_branch;
      logic    branch_ne;     // BNE when set, BEQ otherwise
      logic    is_jump;
   } control_t;

   typedef struct packed {
      word_t pc;
      word_t instruction;
   } if_id_t;

   typedef struct packed {
      word_t    pc;
      reg_id_t  rs1;
      reg_id_t  rs2;
      reg_id_t  rd;
      word_t    data1;
      word_t    data2;
      word_t    immediate;
      control_t control;
   } id_ex_t;

   typedef struct packed {
      reg_id_t  rd;
      word_t    alu_data;     // Result or memory address
      word_t    store_data;
      control_t control;
   } ex_mem_t;

   typedef struct packed {
      reg_id_t  rd;
      word_t    alu_data;
      word_t    memory_data;
      control_t control;
   } mem_wb_t;

   typedef struct packed {
      logic  valid;   // Taken branch or JAL
      word_t target;
   } redirect_t;

endpackage

`default_nettype wire

// ==== fetch_stage.sv ====
`default_nettype none

module fetch_stage (
   input  wire logic                clk,
   input  wire logic                rst_n,
   input  wire logic                pc_stall,   // Load-use hold
   input  wire cpu_pkg::redirect_t  redirect,   // From execute
   output cpu_pkg::word_t           pc          // Also the instruction memory address
);

   cpu_pkg::word_t pc_q;   // Current fetch address

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc_q <= '0;                         // Boot at address zero
      end else if (redirect.valid) begin
         pc_q <= redirect.target;            // Redirect beats increment
      end else if (!pc_stall) begin
         pc_q <= pc_q + cpu_pkg::word_t'(4); // Sequential fetch
      end
   end

   // Held during reset too since the register is cleared every cycle
   assign pc = pc_q;

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`default_nettype none

module decode_stage (
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire cpu_pkg::if_id_t   if_id,
   input  wire logic              wb_en,       // Write-back strobe
   input  wire cpu_pkg::reg_id_t  wb_rd,
   input  wire cpu_pkg::word_t    wb_data,
   output cpu_pkg::id_ex_t        id_ex_next
);

   cpu_pkg::word_t    regs [cpu_pkg::NUM_REGS];   // Register file
   cpu_pkg::word_t    instr;
   logic [6:0]        opcode;
   logic [2:0]        funct3;
   logic              funct7_b5;                  // SUB select
   cpu_pkg::reg_id_t  rs1;
   cpu_pkg::reg_id_t  rs2;
   cpu_pkg::control_t ctrl;
   cpu_pkg::word_t    imm;

   assign instr     = if_id.instruction;
   assign opcode    = instr[6:0];
   assign funct3    = instr[14:12];
   assign funct7_b5 = instr[30];
   assign rs1       = instr[19:15];
   assign rs2       = instr[24:20];

   // Read port with same-cycle write bypass
   function automatic cpu_pkg::word_t rf_read(cpu_pkg::reg_id_t idx, logic en,
                                              cpu_pkg::reg_id_t wr_idx,
                                              cpu_pkg::word_t wr_val,
                                              cpu_pkg::word_t stored);
      if (idx == '0) return '0;                 // x0 hardwired
      if (en && wr_idx == idx) return wr_val;   // Write-through
      return stored;
   endfunction

   always_comb begin : decode
      ctrl = '0;   // Unknown opcode stays a NOP
      imm  = '0;
      case (opcode)
         cpu_pkg::OP_REG: begin
            ctrl.reg_write = 1'b1;
            case (funct3)
               3'b000: begin
                  if (funct7_b5) ctrl.alu_op = cpu_pkg::ALU_SUB;
                  else           ctrl.alu_op = cpu_pkg::ALU_ADD;
               end
               3'b111:  ctrl.alu_op = cpu_pkg::ALU_AND;
               3'b110:  ctrl.alu_op = cpu_pkg::ALU_OR;
               3'b100:  ctrl.alu_op = cpu_pkg::ALU_XOR;
               3'b010:  ctrl.alu_op = cpu_pkg::ALU_SLT;
               default: ctrl.reg_write = 1'b0;   // Unsupported R-type
            endcase
         end
         cpu_pkg::OP_IMM: begin
            imm              = {{20{instr[31]}}, instr[31:20]};   // I-type
            ctrl.alu_src_imm = (funct3 == 3'b000);                // ADDI only
            ctrl.reg_write   = (funct3 == 3'b000);
         end
         cpu_pkg::OP_LUI: begin
            imm              = {instr[31:12], 12'b0};             // U-type
            ctrl.alu_op      = cpu_pkg::ALU_PASSB;
            ctrl.alu_src_imm = 1'b1;
            ctrl.reg_write   = 1'b1;
         end
         cpu_pkg::OP_LOAD: begin
            imm              = {{20{instr[31]}}, instr[31:20]};
            ctrl.alu_src_imm = (funct3 == 3'b010);                // LW only
            ctrl.reg_write   = (funct3 == 3'b010);
            ctrl.mem_read    = (funct3 == 3'b010);
         end
         cpu_pkg::OP_STORE: begin
            imm              = {{20{instr[31]}}, instr[31:25], instr[11:7]};   // S-type
            ctrl.alu_src_imm = (funct3 == 3'b010);                // SW only
            ctrl.mem_write   = (funct3 == 3'b010);
         end
         cpu_pkg::OP_BRANCH: begin
            imm            = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                              instr[11:8], 1'b0};                 // B-type
            ctrl.is_branch = (funct3[2:1] == 2'b00);              // BEQ or BNE
            ctrl.branch_ne = (funct3[2:1] == 2'b00) && funct3[0];
         end
         cpu_pkg::OP_JAL: begin
            imm            = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                              instr[30:21], 1'b0};                // J-type
            ctrl.is_jump   = 1'b1;
            ctrl.reg_write = 1'b1;                                // Link register
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < cpu_pkg::NUM_REGS; i++) regs[i] <= '0;   // Clean start
      end else if (wb_en && wb_rd != '0) begin
         regs[wb_rd] <= wb_data;
      end
   end

   always_comb begin
      id_ex_next.pc        = if_id.pc;
      id_ex_next.rs1       = rs1;
      id_ex_next.rs2       = rs2;
      id_ex_next.rd        = instr[11:7];
      id_ex_next.data1     = rf_read(rs1, wb_en, wb_rd, wb_data, regs[rs1]);
      id_ex_next.data2     = rf_read(rs2, wb_en, wb_rd, wb_data, regs[rs2]);
      id_ex_next.immediate = imm;
      id_ex_next.control   = ctrl;
   end

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
`default_nettype none

module execute_stage (
   input  wire cpu_pkg::id_ex_t    id_ex,
   input  wire cpu_pkg::fwd_sel_e  fwd_sel_rs1,
   input  wire cpu_pkg::fwd_sel_e  fwd_sel_rs2,
   input  wire cpu_pkg::word_t     ex_mem_alu,    // EX/MEM result
   input  wire cpu_pkg::word_t     wb_result,     // Write-back value
   output cpu_pkg::ex_mem_t        ex_mem_next,
   output cpu_pkg::redirect_t      redirect
);

   cpu_pkg::word_t op_a;       // Forwarded rs1
   cpu_pkg::word_t op_b_reg;   // Forwarded rs2
   cpu_pkg::word_t op_b;       // ALU operand B
   cpu_pkg::word_t alu_y;
   cpu_pkg::word_t link_pc;    // Return address for JAL
   logic           equal;
   logic           taken;

   function automatic cpu_pkg::word_t fwd_mux(cpu_pkg::fwd_sel_e sel,
                                              cpu_pkg::word_t reg_val,
                                              cpu_pkg::word_t from_ex_mem,
                                              cpu_pkg::word_t from_mem_wb);
      case (sel)
         cpu_pkg::FWD_EX_MEM: return from_ex_mem;
         cpu_pkg::FWD_MEM_WB: return from_mem_wb;
         default:             return reg_val;
      endcase
   endfunction

   assign op_a     = fwd_mux(fwd_sel_rs1, id_ex.data1, ex_mem_alu, wb_result);
   assign op_b_reg = fwd_mux(fwd_sel_rs2, id_ex.data2, ex_mem_alu, wb_result);
   assign op_b     = id_ex.control.alu_src_imm ? id_ex.immediate : op_b_reg;
   assign link_pc  = id_ex.pc + cpu_pkg::word_t'(4);

   always_comb begin : alu
      case (id_ex.control.alu_op)
         cpu_pkg::ALU_ADD:   alu_y = op_a + op_b;
         cpu_pkg::ALU_SUB:   alu_y = op_a - op_b;
         cpu_pkg::ALU_AND:   alu_y = op_a & op_b;
         cpu_pkg::ALU_OR:    alu_y = op_a | op_b;
         cpu_pkg::ALU_XOR:   alu_y = op_a ^ op_b;
         cpu_pkg::ALU_SLT:   alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
         cpu_pkg::ALU_PASSB: alu_y = op_b;
         default:            alu_y = op_a + op_b;
      endcase
   end

   // Branch compare uses register operands and never the immediate
   assign equal = (op_a == op_b_reg);
   assign taken = id_ex.control.is_branch && (equal != id_ex.control.branch_ne);

   assign redirect.valid  = taken || id_ex.control.is_jump;   // Static not-taken miss
   assign redirect.target = id_ex.pc + id_ex.immediate;       // PC relative

   always_comb begin
      ex_mem_next.rd         = id_ex.rd;
      ex_mem_next.alu_data   = id_ex.control.is_jump ? link_pc : alu_y;
      ex_mem_next.store_data = op_b_reg;                      // SW data
      ex_mem_next.control    = id_ex.control;
   end

endmodule

`default_nettype wire

// ==== mem_stage.sv ====
`default_nettype none

module mem_stage (
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire cpu_pkg::ex_mem_t  ex_mem,
   output cpu_pkg::mem_wb_t       mem_wb_next
);

   cpu_pkg::word_t     dmem [cpu_pkg::DMEM_WORDS];   // Word-wide data memory
   cpu_pkg::dmem_idx_t idx;

   // Word address with upper bits ignored so the array wraps
   assign idx = ex_mem.alu_data[7:2];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < cpu_pkg::DMEM_WORDS; i++) dmem[i] <= '0;   // Zero fill
      end else if (ex_mem.control.mem_write) begin
         dmem[idx] <= ex_mem.store_data;   // SW
      end
   end

   always_comb begin
      mem_wb_next.rd          = ex_mem.rd;
      mem_wb_next.alu_data    = ex_mem.alu_data;
      mem_wb_next.memory_data = dmem[idx];   // Async read for LW
      mem_wb_next.control     = ex_mem.control;
   end

endmodule

`default_nettype wire

// ==== hazard_unit.sv ====
`default_nettype none

module hazard_unit (
   input  wire cpu_pkg::if_id_t     if_id,
   input  wire cpu_pkg::id_ex_t     id_ex,
   input  wire cpu_pkg::ex_mem_t    ex_mem,
   input  wire cpu_pkg::mem_wb_t    mem_wb,
   input  wire cpu_pkg::redirect_t  redirect,
   output logic                     pc_stall,
   output logic                     if_id_stall,
   output logic                     if_id_flush,
   output logic                     id_ex_flush,
   output cpu_pkg::fwd_sel_e        fwd_sel_rs1,
   output cpu_pkg::fwd_sel_e        fwd_sel_rs2
);

   cpu_pkg::reg_id_t if_rs1;     // Raw fields even if unused by the format
   cpu_pkg::reg_id_t if_rs2;
   logic             load_use;

   // Younger producer wins
   function automatic cpu_pkg::fwd_sel_e fwd_pick(cpu_pkg::reg_id_t rs,
                                                  cpu_pkg::ex_mem_t em,
                                                  cpu_pkg::mem_wb_t mw);
      if (em.control.reg_write && em.rd != '0 && em.rd == rs) return cpu_pkg::FWD_EX_MEM;
      if (mw.control.reg_write && mw.rd != '0 && mw.rd == rs) return cpu_pkg::FWD_MEM_WB;
      return cpu_pkg::FWD_NONE;
   endfunction

   assign if_rs1 = if_id.instruction[19:15];
   assign if_rs2 = if_id.instruction[24:20];

   assign load_use = id_ex.control.mem_read && id_ex.rd != '0 &&
                     (id_ex.rd == if_rs1 || id_ex.rd == if_rs2);

   assign pc_stall    = load_use;                       // Hold fetch
   assign if_id_stall = load_use;                       // Hold consumer in decode
   assign id_ex_flush = load_use || redirect.valid;     // Bubble or squash
   assign if_id_flush = redirect.valid && !load_use;    // Load-use first

   assign fwd_sel_rs1 = fwd_pick(id_ex.rs1, ex_mem, mem_wb);
   assign fwd_sel_rs2 = fwd_pick(id_ex.rs2, ex_mem, mem_wb);

endmodule

`default_nettype wire

// ==== cpu.sv ====
`default_nettype none

module cpu (
   input  wire logic              clk,
   input  wire logic              rst_n,
   output cpu_pkg::word_t         imem_addr,
   input  wire cpu_pkg::word_t    imem_data,   // Combinational read of imem_addr
   output logic                   wb_valid,    // One pulse per retire
   output cpu_pkg::reg_id_t       wb_rd,
   output cpu_pkg::word_t         wb_data
);

   // Pipeline registers
   cpu_pkg::if_id_t    if_id;
   cpu_pkg::id_ex_t    id_ex;
   cpu_pkg::ex_mem_t   ex_mem;
   cpu_pkg::mem_wb_t   mem_wb;

   // Stage outputs feeding the registers
   cpu_pkg::id_ex_t    id_ex_next;
   cpu_pkg::ex_mem_t   ex_mem_next;
   cpu_pkg::mem_wb_t   mem_wb_next;
   cpu_pkg::redirect_t redirect;

   logic               pc_stall;
   logic               if_id_stall;
   logic               if_id_flush;
   logic               id_ex_flush;
   cpu_pkg::fwd_sel_e  fwd_sel_rs1;
   cpu_pkg::fwd_sel_e  fwd_sel_rs2;

   fetch_stage fetch_stage_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .pc_stall (pc_stall),
      .redirect (redirect),
      .pc       (imem_addr)
   );

   always_ff @(posedge clk) begin
      if (!rst_n || if_id_flush) begin
         if_id <= '{pc: '0, instruction: cpu_pkg::NOP_INSTR};   // Squash to NOP
      end else if (!if_id_stall) begin
         if_id <= '{pc: imem_addr, instruction: imem_data};
      end
   end

   decode_stage decode_stage_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .if_id      (if_id),
      .wb_en      (wb_valid),
      .wb_rd      (wb_rd),
      .wb_data    (wb_data),
      .id_ex_next (id_ex_next)
   );

   always_ff @(posedge clk) begin
      if (!rst_n || id_ex_flush) id_ex <= '0;   // Bubble has no control bits
      else                       id_ex <= id_ex_next;
   end

   execute_stage execute_stage_inst (
      .id_ex       (id_ex),
      .fwd_sel_rs1 (fwd_sel_rs1),
      .fwd_sel_rs2 (fwd_sel_rs2),
      .ex_mem_alu  (ex_mem.alu_data),
      .wb_result   (wb_data),
      .ex_mem_next (ex_mem_next),
      .redirect    (redirect)
   );

   always_ff @(posedge clk) begin
      if (!rst_n) ex_mem <= '0;
      else        ex_mem <= ex_mem_next;
   end

   mem_stage mem_stage_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .ex_mem      (ex_mem),
      .mem_wb_next (mem_wb_next)
   );

   always_ff @(posedge clk) begin
      if (!rst_n) mem_wb <= '0;
      else        mem_wb <= mem_wb_next;
   end

   hazard_unit hazard_unit_inst (
      .if_id       (if_id),
      .id_ex       (id_ex),
      .ex_mem      (ex_mem),
      .mem_wb      (mem_wb),
      .redirect    (redirect),
      .pc_stall    (pc_stall),
      .if_id_stall (if_id_stall),
      .if_id_flush (if_id_flush),
      .id_ex_flush (id_ex_flush),
      .fwd_sel_rs1 (fwd_sel_rs1),
      .fwd_sel_rs2 (fwd_sel_rs2)
   );

   // Write-back select
   assign wb_valid = mem_wb.control.reg_write && mem_wb.rd != '0;   // x0 never retires
   assign wb_rd    = mem_wb.rd;
   assign wb_data  = mem_wb.control.mem_read ? mem_wb.memory_data : mem_wb.alu_data;

endmodule

`default_nettype wire

// ==== cpu_tb_model.svh ====
`ifndef CPU_TB_MODEL_SVH
`define CPU_TB_MODEL_SVH

cpu_pkg::word_t model_regs [32];   // Reference register file
cpu_pkg::word_t model_mem  [64];   // Reference data memory

// Runs prog in order and queues each expected retire in exp_rd and exp_data
task automatic run_model();
   cpu_pkg::word_t pc;
   cpu_pkg::word_t next_pc;
   cpu_pkg::word_t ins;
   cpu_pkg::word_t a;
   cpu_pkg::word_t b;
   cpu_pkg::word_t imm_i;
   cpu_pkg::word_t addr;
   cpu_pkg::word_t result;
   logic           writes;
   pc = '0;
   for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
   end
   for (int m = 0; m < 64; m++) begin
      model_mem[m] = '0;   // Untouched words read zero
   end
   while (pc < PROG_LEN * 4) begin   // Jumps only go forward so this ends
      ins     = prog[pc[9:2]];
      a       = model_regs[ins[19:15]];
      b       = model_regs[ins[24:20]];
      imm_i   = {{20{ins[31]}}, ins[31:20]};
      next_pc = pc + 32'd4;
      writes  = 1'b1;
      result  = '0;
      case (ins[6:0])
         cpu_pkg::OP_REG: begin
            case ({ins[30], ins[14:12]})   // funct7 bit 5 and funct3
               4'b0000: result = a + b;
               4'b1000: result = a - b;
               4'b0111: result = a & b;
               4'b0110: result = a | b;
               4'b0100: result = a ^ b;
               4'b0010: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               default: writes = 1'b0;
            endcase
         end
         cpu_pkg::OP_IMM: result = a + imm_i;               // ADDI
         cpu_pkg::OP_LUI: result = {ins[31:12], 12'h000};
         cpu_pkg::OP_LOAD: begin
            addr   = a + imm_i;
            result = model_mem[addr[7:2]];
         end
         cpu_pkg::OP_STORE: begin
            addr   = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            writes = 1'b0;
            model_mem[addr[7:2]] = b;
         end
         cpu_pkg::OP_BRANCH: begin
            writes = 1'b0;
            if ((a == b) != ins[12]) begin   // funct3 bit 0 selects BNE
               next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
         end
         cpu_pkg::OP_JAL: begin
            result  = pc + 32'd4;   // Link value
            next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
         end
         default: writes = 1'b0;
      endcase
      if (writes && ins[11:7] != 5'd0) begin   // x0 writes vanish
         model_regs[ins[11:7]] = result;
         exp_rd.push_back(ins[11:7]);
         exp_data.push_back(result);
      end
      pc = next_pc;
   end
endtask

`endif

// ==== cpu_tb.sv ====
`default_nettype none

module cpu_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int PROG_LEN       = 200;   // Random instructions
   localparam int PROG_WORDS     = 256;   // Program plus NOP padding
   localparam int RETIRE_TIMEOUT = 50;    // Cycles allowed per retire
   localparam int DRAIN_CYCLES   = 20;    // Quiet cycles after the last retire

   logic             clk = 1'b0;
   logic             rst_n;
   cpu_pkg::word_t   imem_addr;
   cpu_pkg::word_t   imem_data;
   logic             wb_valid;
   cpu_pkg::reg_id_t wb_rd;
   cpu_pkg::word_t   wb_data;

   cpu_pkg::word_t   prog [PROG_WORDS];
   cpu_pkg::reg_id_t exp_rd [$];     // Expected retires in order
   cpu_pkg::word_t   exp_data [$];
   int               retired = 0;

   `include "cpu_tb_model.svh"

   cpu cpu_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .imem_addr (imem_addr),
      .imem_data (imem_data),
      .wb_valid  (wb_valid),
      .wb_rd     (wb_rd),
      .wb_data   (wb_data)
   );

   always #4 clk = ~clk;   // 8 ns period

   // Instruction memory read settles before the next rising edge
   always @(negedge clk) begin
      imem_data = fetch_word(imem_addr);
   end

   function automatic cpu_pkg::word_t fetch_word(cpu_pkg::word_t addr);
      cpu_pkg::word_t idx;
      idx = addr >> 2;
      if (idx < PROG_WORDS) return prog[idx[7:0]];
      return cpu_pkg::NOP_INSTR;   // Beyond the array
   endfunction

   function automatic cpu_pkg::word_t r_type(logic [6:0] funct7, logic [2:0] funct3,
                                             cpu_pkg::reg_id_t rd, cpu_pkg::reg_id_t rs1,
                                             cpu_pkg::reg_id_t rs2);
      return {funct7, rs2, rs1, funct3, rd, cpu_pkg::OP_REG};
   endfunction

   function automatic cpu_pkg::word_t i_type(logic [6:0] opcode, logic [2:0] funct3,
                                             cpu_pkg::reg_id_t rd, cpu_pkg::reg_id_t rs1,
                                             logic [11:0] imm);
      return {imm, rs1, funct3, rd, opcode};
   endfunction

   function automatic cpu_pkg::word_t s_type(logic [11:0] imm, cpu_pkg::reg_id_t rs2,
                                             cpu_pkg::reg_id_t rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpu_pkg::OP_STORE};   // SW
   endfunction

   function automatic cpu_pkg::word_t b_type(logic [12:0] off, logic [2:0] funct3,
                                             cpu_pkg::reg_id_t rs1, cpu_pkg::reg_id_t rs2);
      return {off[12], off[10:5], rs2, rs1, funct3, off[4:1], off[11], cpu_pkg::OP_BRANCH};
   endfunction

   function automatic cpu_pkg::word_t j_type(logic [20:0] off, cpu_pkg::reg_id_t rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, cpu_pkg::OP_JAL};
   endfunction

   // Mostly a few hot words so loads meet earlier stores
   function automatic int unsigned word_pick();
      if ($urandom_range(3, 0) == 0) return $urandom_range(63, 0);
      return $urandom_range(7, 0);
   endfunction

   task automatic make_program();
      int unsigned      kind;
      cpu_pkg::reg_id_t rd;
      cpu_pkg::reg_id_t rs1;
      cpu_pkg::reg_id_t rs2;
      logic [11:0]      mem_off;
      logic [12:0]      br_off;
      for (int i = 0; i < PROG_WORDS; i++) begin
         prog[i] = cpu_pkg::NOP_INSTR;   // Padding
      end
      for (int i = 0; i < PROG_LEN; i++) begin
         kind    = $urandom_range(15, 0);
         rd      = cpu_pkg::reg_id_t'($urandom_range(7, 0));   // x0 to x7 only
         rs1     = cpu_pkg::reg_id_t'($urandom_range(7, 0));
         rs2     = cpu_pkg::reg_id_t'($urandom_range(7, 0));
         mem_off = 12'(word_pick() * 4);
         br_off  = 13'($urandom_range(8, 2) * 4);   // 2 to 8 instructions ahead
         case (kind)
            0:       prog[i] = r_type(7'h00, 3'b000, rd, rs1, rs2);   // ADD
            1:       prog[i] = r_type(7'h20, 3'b000, rd, rs1, rs2);   // SUB
            2:       prog[i] = r_type(7'h00, 3'b111, rd, rs1, rs2);   // AND
            3:       prog[i] = r_type(7'h00, 3'b110, rd, rs1, rs2);   // OR
            4:       prog[i] = r_type(7'h00, 3'b100, rd, rs1, rs2);   // XOR
            5:       prog[i] = r_type(7'h00, 3'b010, rd, rs1, rs2);   // SLT
            6, 7:    prog[i] = i_type(cpu_pkg::OP_IMM, 3'b000, rd, rs1, 12'($urandom));
            8:       prog[i] = {20'($urandom), rd, cpu_pkg::OP_LUI};
            9, 10:   prog[i] = i_type(cpu_pkg::OP_LOAD, 3'b010, rd, 5'd0, mem_off);
            11, 12:  prog[i] = s_type(mem_off, rs2, 5'd0);
            13:      prog[i] = b_type(br_off, 3'b000, rs1, rs2);      // BEQ
            14:      prog[i] = b_type(br_off, 3'b001, rs1, rs2);      // BNE
            default: prog[i] = j_type(21'(br_off), rd);
         endcase
      end
   endtask

   task automatic stop_failed();
      $display("Finished with errors");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input cpu_pkg::word_t actual,
                              input cpu_pkg::word_t expected);
      if (actual !== expected) begin
         $display("[FAIL] %s: got 0x%h, expected 0x%h at retire %0d",
                  name, actual, expected, retired);
         stop_failed();
      end
   endtask

   // Sampled on the falling edge where the write-back outputs are stable
   task automatic wait_retire(output logic seen);
      int cycles;
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles < RETIRE_TIMEOUT) begin
         @(negedge clk);
         seen = wb_valid;
         cycles++;
      end
   endtask

   initial begin
      logic seen;
      void'($urandom(32'h3dd3_dd28));   // One seed for the whole run
      rst_n     = 1'b0;
      imem_data = cpu_pkg::NOP_INSTR;
      make_program();
      run_model();
      $display("Program of %0d instructions, %0d expected retires", PROG_LEN, exp_rd.size());
      repeat (2) @(posedge clk);   // Reset for 2 cycles
      @(negedge clk);
      check_value("imem_addr", imem_addr, '0);   // PC parked at zero in reset
      check_value("wb_valid", cpu_pkg::word_t'(wb_valid), '0);
      rst_n = 1'b1;
      @(negedge clk);
      check_value("imem_addr", imem_addr, 32'd4);   // First sequential step
      while (exp_rd.size() > 0) begin
         wait_retire(seen);
         if (!seen) begin
            $display("Timed out after %0d cycles with %0d expected retires left",
                     RETIRE_TIMEOUT, exp_rd.size());
            stop_failed();
         end else begin
            check_value("wb_rd", cpu_pkg::word_t'(wb_rd), cpu_pkg::word_t'(exp_rd.pop_front()));
            check_value("wb_data", wb_data, exp_data.pop_front());
            retired++;
         end
      end
      for (int c = 0; c < DRAIN_CYCLES; c++) begin   // Padding NOPs must stay silent
         @(negedge clk);
         if (wb_valid) begin
            $display("Unexpected retire to x%0d after all expected retires", wb_rd);
            stop_failed();
         end
      end
      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_stage.sv
hazard_unit.sv
cpu.sv
cpu_tb.sv

// ==== Makefile ====
TOP := cpu_tb

.PHONY: sim clean

sim:
	verilator --binary --timescale 1ns/1ps -f verilog.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "Finished with no errors" > /dev/null

clean:
	rm -rf obj_dir
